// File: decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Instruction field positions
`define FLD_OP    31:26
`define FLD_RT    20:16
`define FLD_FUNCT 5:0

// Primary opcodes
`define OP_RTYPE  6'b000000
`define OP_REGIMM 6'b000001
`define OP_J      6'b000010
`define OP_JAL    6'b000011
`define OP_BEQ    6'b000100
`define OP_BNE    6'b000101
`define OP_BLEZ   6'b000110
`define OP_BGTZ   6'b000111
`define OP_ADDI   6'b001000
`define OP_ADDIU  6'b001001
`define OP_SLTI   6'b001010
`define OP_SLTIU  6'b001011
`define OP_ANDI   6'b001100
`define OP_ORI    6'b001101
`define OP_XORI   6'b001110
`define OP_LUI    6'b001111
`define OP_LB     6'b100000
`define OP_LH     6'b100001
`define OP_LW     6'b100011
`define OP_LBU    6'b100100
`define OP_LHU    6'b100101
`define OP_SB     6'b101000
`define OP_SH     6'b101001
`define OP_SW     6'b101011

// R-type function codes
`define FN_SLL     6'b000000
`define FN_SRL     6'b000010
`define FN_SRA     6'b000011
`define FN_SLLV    6'b000100
`define FN_SRLV    6'b000110
`define FN_SRAV    6'b000111
`define FN_JR      6'b001000
`define FN_JALR    6'b001001
`define FN_SYSCALL 6'b001100
`define FN_BREAK   6'b001101
`define FN_ADD     6'b100000
`define FN_ADDU    6'b100001
`define FN_SUB     6'b100010
`define FN_SUBU    6'b100011
`define FN_AND     6'b100100
`define FN_OR      6'b100101
`define FN_XOR     6'b100110
`define FN_NOR     6'b100111
`define FN_SLT     6'b101010
`define FN_SLTU    6'b101011

// REGIMM branches, selected by the rt field
`define RT_BLTZ   5'b00000
`define RT_BGEZ   5'b00001
`define RT_BLTZAL 5'b10000
`define RT_BGEZAL 5'b10001

`define ALU_ADD  5'd0
`define ALU_SUB  5'd1
`define ALU_OR   5'd2
`define ALU_AND  5'd3
`define ALU_NOR  5'd4
`define ALU_XOR  5'd5
`define ALU_SLL  5'd6
`define ALU_SRL  5'd7
`define ALU_SRA  5'd8
`define ALU_SLT  5'd9
`define ALU_SLTU 5'd10
`define ALU_ADDU 5'd12
`define ALU_SUBU 5'd16
`define ALU_NONE 5'd31 // No ALU work

`define EXC_NONE 5'd0
`define EXC_SYS  5'd8
`define EXC_BP   5'd9
`define EXC_RI   5'd10

`define REG_RA 5'd31 // Link register

`define EXT_ZERO  2'd0
`define EXT_SIGN  2'd1
`define EXT_UPPER 2'd2 // Immediate into the upper half
`define NPC_SEQ    2'd0
`define NPC_BRANCH 2'd1
`define NPC_JIMM   2'd2
`define NPC_JREG   2'd3
`define DM_SB  3'd0
`define DM_SH  3'd1
`define DM_SW  3'd2
`define DM_LBU 3'd3
`define DM_LB  3'd4
`define DM_LHU 3'd5
`define DM_LH  3'd6
`define DM_LW  3'd7
`define DEST_RT 2'd0
`define DEST_RD 2'd1
`define DEST_RA 2'd2
`define WB_LUI 3'd1
`define WB_ALU 3'd2
`define WB_RA  3'd3 // Return address
`define WB_MEM 3'd4

`endif

// File: decodePkg.sv
package decodePkg;

	typedef logic [31:0] word_t;   // Instruction or operand word
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [4:0] aluOp_t;
	typedef logic [1:0] extOp_t;   // Zero, sign or upper
	typedef logic [1:0] npcOp_t;   // Sequential, taken, jump imm, jump reg
	typedef logic [2:0] dmSel_t;   // Access size and signedness
	typedef logic [1:0] destSel_t; // rt, rd or r31
	typedef logic [2:0] wbSel_t;
	typedef logic [4:0] excCode_t;

endpackage

// File: aluDecode.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module aluDecode (
	input  decodePkg::opcode_t opcode,
	input  decodePkg::funct_t  funct,
	output decodePkg::aluOp_t  aluOp,
	output logic               shiftByShamt,
	output decodePkg::extOp_t  extOp
);

	// Constant shifts take the amount from shamt, variable ones from rs
	assign shiftByShamt = (opcode == `OP_RTYPE) &&
		(funct == `FN_SLL || funct == `FN_SRL || funct == `FN_SRA);

	always_comb begin
		aluOp = `ALU_NONE;
		if (opcode == `OP_RTYPE) begin
			case (funct)
				`FN_ADD:            aluOp = `ALU_ADD;
				`FN_ADDU:           aluOp = `ALU_ADDU;
				`FN_SUB:            aluOp = `ALU_SUB;
				`FN_SUBU:           aluOp = `ALU_SUBU;
				`FN_AND:            aluOp = `ALU_AND;
				`FN_OR:             aluOp = `ALU_OR;
				`FN_XOR:            aluOp = `ALU_XOR;
				`FN_NOR:            aluOp = `ALU_NOR;
				`FN_SLT:            aluOp = `ALU_SLT;
				`FN_SLTU:           aluOp = `ALU_SLTU;
				`FN_SLL, `FN_SLLV:  aluOp = `ALU_SLL;
				`FN_SRL, `FN_SRLV:  aluOp = `ALU_SRL;
				`FN_SRA, `FN_SRAV:  aluOp = `ALU_SRA;
				default:            aluOp = `ALU_NONE; // JR, JALR, traps to OS
			endcase
		end else begin
			case (opcode)
				`OP_ADDI:           aluOp = `ALU_ADD;
				`OP_ADDIU:          aluOp = `ALU_ADDU;
				`OP_SLTI:           aluOp = `ALU_SLT;
				`OP_SLTIU:          aluOp = `ALU_SLTU;
				`OP_ANDI:           aluOp = `ALU_AND;
				`OP_ORI:            aluOp = `ALU_OR;
				`OP_XORI:           aluOp = `ALU_XOR;
				`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW,
				`OP_SB, `OP_SH, `OP_SW: aluOp = `ALU_ADD; // Address base plus offset
				default:            aluOp = `ALU_NONE;
			endcase
		end
	end

	always_comb begin
		case (opcode)
			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
			`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW,
			`OP_SB, `OP_SH, `OP_SW:   extOp = `EXT_SIGN;
			`OP_LUI:                  extOp = `EXT_UPPER;
			default:                  extOp = `EXT_ZERO; // Logical immediates
		endcase
	end

endmodule

// File: memDecode.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module memDecode (
	input  decodePkg::opcode_t opcode,
	output logic               memRead,
	output logic               memWrite,
	output decodePkg::dmSel_t  dmSel
);

	assign memRead  = opcode inside {`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW};
	assign memWrite = opcode inside {`OP_SB, `OP_SH, `OP_SW};

	always_comb begin
		case (opcode)
			`OP_SB:  dmSel = `DM_SB;
			`OP_SH:  dmSel = `DM_SH;
			`OP_SW:  dmSel = `DM_SW;
			`OP_LBU: dmSel = `DM_LBU;
			`OP_LB:  dmSel = `DM_LB;
			`OP_LHU: dmSel = `DM_LHU;
			`OP_LH:  dmSel = `DM_LH;
			default: dmSel = `DM_LW; // Full word also when nothing is accessed
		endcase
	end

endmodule

// File: branchResolve.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module branchResolve (
	input  decodePkg::opcode_t  opcode,
	input  decodePkg::funct_t   funct,
	input  decodePkg::regAddr_t rt,
	input  decodePkg::word_t    rsVal,
	input  decodePkg::word_t    rtVal,
	output logic                isBranch,
	output decodePkg::npcOp_t   npcOp
);

	logic equal;
	logic rsNeg;
	logic rsZero;
	logic isJumpImm;
	logic isJumpReg;
	logic isRegimmBr;
	logic taken;

	assign equal  = (rsVal == rtVal);
	assign rsNeg  = rsVal[31];
	assign rsZero = (rsVal == '0);

	assign isJumpImm  = (opcode == `OP_J) || (opcode == `OP_JAL);
	assign isJumpReg  = (opcode == `OP_RTYPE) && (funct == `FN_JR || funct == `FN_JALR);
	assign isRegimmBr = (opcode == `OP_REGIMM) &&
		(rt inside {`RT_BLTZ, `RT_BGEZ, `RT_BLTZAL, `RT_BGEZAL});

	always_comb begin
		case (opcode)
			`OP_BEQ:    taken = equal;
			`OP_BNE:    taken = !equal;
			`OP_BLEZ:   taken = rsNeg || rsZero;
			`OP_BGTZ:   taken = !rsNeg && !rsZero;
			// rt bit 0 tells the BGEZ forms from the BLTZ forms
			`OP_REGIMM: taken = isRegimmBr && (rt[0] ? !rsNeg : rsNeg);
			default:    taken = 1'b0;
		endcase
	end

	assign isBranch = isJumpImm || isJumpReg || isRegimmBr ||
		(opcode inside {`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ});

	always_comb begin
		if (isJumpImm)
			npcOp = `NPC_JIMM;
		else if (isJumpReg)
			npcOp = `NPC_JREG; // Target from rs
		else if (taken)
			npcOp = `NPC_BRANCH;
		else
			npcOp = `NPC_SEQ;
	end

endmodule

// File: regWriteDecode.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module regWriteDecode (
	input  decodePkg::opcode_t  opcode,
	input  decodePkg::funct_t   funct,
	input  decodePkg::regAddr_t rt,
	output logic                regWrite,
	output decodePkg::destSel_t destSel,
	output decodePkg::wbSel_t   wbSel
);

	logic isRtype;
	logic rtypeWrite;
	logic isLoad;
	logic isLinkRegimm;
	logic immWrite;

	assign isRtype    = (opcode == `OP_RTYPE);
	assign rtypeWrite = funct inside {`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU,
		`FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU,
		`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV, `FN_JALR};
	assign isLoad = opcode inside {`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW};
	assign isLinkRegimm = (opcode == `OP_REGIMM) && (rt == `RT_BGEZAL || rt == `RT_BLTZAL);
	assign immWrite = opcode inside {`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
		`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI};

	assign regWrite = (isRtype && rtypeWrite) || immWrite || isLoad ||
		isLinkRegimm || (opcode == `OP_JAL);

	always_comb begin
		if (isRtype)
			destSel = `DEST_RD;
		else if (opcode == `OP_JAL || isLinkRegimm)
			destSel = `DEST_RA; // Link into r31
		else
			destSel = `DEST_RT;
	end

	always_comb begin
		if (isLoad)
			wbSel = `WB_MEM;
		else if (opcode == `OP_LUI)
			wbSel = `WB_LUI;
		else if (opcode == `OP_JAL || isLinkRegimm || (isRtype && funct == `FN_JALR))
			wbSel = `WB_RA;
		else
			wbSel = `WB_ALU;
	end

endmodule

// File: excDetect.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module excDetect (
	input  decodePkg::opcode_t  opcode,
	input  decodePkg::funct_t   funct,
	input  logic                regWrite,
	input  logic                memWrite,
	input  logic                isBranch,
	output logic                exception,
	output decodePkg::excCode_t excCode
);

	logic isSyscall;
	logic isBreak;
	logic recognized;

	assign isSyscall  = (opcode == `OP_RTYPE) && (funct == `FN_SYSCALL);
	assign isBreak    = (opcode == `OP_RTYPE) && (funct == `FN_BREAK);
	// Anything the other units act on counts as a valid instruction
	assign recognized = regWrite || memWrite || isBranch || isSyscall || isBreak;

	always_comb begin
		exception = 1'b1;
		if (!recognized)
			excCode = `EXC_RI;
		else if (isBreak)
			excCode = `EXC_BP;
		else if (isSyscall)
			excCode = `EXC_SYS;
		else begin
			exception = 1'b0;
			excCode = `EXC_NONE;
		end
	end

endmodule

// File: decodeStage.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module decodeStage (
	input  logic                clk,
	input  logic                rst,
	input  logic                req,
	output logic                ack,
	input  decodePkg::aluOp_t   aluOpDec,
	input  logic                shiftByShamtDec,
	input  decodePkg::extOp_t   extOpDec,
	input  logic                memReadDec,
	input  logic                memWriteDec,
	input  decodePkg::dmSel_t   dmSelDec,
	input  logic                regWriteDec,
	input  decodePkg::destSel_t destSelDec,
	input  decodePkg::wbSel_t   wbSelDec,
	input  decodePkg::npcOp_t   npcOpDec,
	input  logic                isBranchDec,
	input  logic                exceptionDec,
	input  decodePkg::excCode_t excCodeDec,
	output decodePkg::aluOp_t   aluOp,
	output logic                shiftByShamt,
	output decodePkg::extOp_t   extOp,
	output logic                memRead,
	output logic                memWrite,
	output decodePkg::dmSel_t   dmSel,
	output logic                regWrite,
	output decodePkg::destSel_t destSel,
	output decodePkg::wbSel_t   wbSel,
	output decodePkg::npcOp_t   npcOp,
	output logic                isBranch,
	output logic                inDelaySlot,
	output logic                exception,
	output decodePkg::excCode_t excCode
);

	typedef enum logic {
		Idle,  // Waiting for req
		Acked  // Word held and ack high until req drops
	} hsState_t;

	hsState_t state;
	logic capture;

	assign capture = (state == Idle) && req;
	assign ack = (state == Acked);

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= Idle;
			regWrite <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
			npcOp <= `NPC_SEQ;
			isBranch <= 1'b0;
			inDelaySlot <= 1'b0;
			exception <= 1'b0;
			excCode <= `EXC_NONE;
		end else if (capture) begin
			state <= Acked;
			regWrite <= regWriteDec;
			memRead <= memReadDec;
			memWrite <= memWriteDec;
			npcOp <= npcOpDec;
			isBranch <= isBranchDec;
			inDelaySlot <= isBranch; // Still the flag of the previous word
			exception <= exceptionDec;
			excCode <= excCodeDec;
		end else if (state == Acked && !req) begin
			state <= Idle;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			aluOp <= aluOpDec;
			shiftByShamt <= shiftByShamtDec;
			extOp <= extOpDec;
			dmSel <= dmSelDec;
			destSel <= destSelDec;
			wbSel <= wbSelDec;
		end
	end

endmodule

// File: idDecode.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module idDecode (
	input  logic                clk,
	input  logic                rst,
	input  logic                req,
	output logic                ack,
	input  decodePkg::word_t    instr,
	input  decodePkg::word_t    rsVal,
	input  decodePkg::word_t    rtVal,
	output decodePkg::aluOp_t   aluOp,
	output logic                shiftByShamt,
	output decodePkg::extOp_t   extOp,
	output logic                memRead,
	output logic                memWrite,
	output decodePkg::dmSel_t   dmSel,
	output logic                regWrite,
	output decodePkg::destSel_t destSel,
	output decodePkg::wbSel_t   wbSel,
	output decodePkg::npcOp_t   npcOp,
	output logic                isBranch,
	output logic                inDelaySlot,
	output logic                exception,
	output decodePkg::excCode_t excCode
);
	import decodePkg::*;

	opcode_t  opcode;
	funct_t   funct;
	regAddr_t rt;
	aluOp_t   aluOpDec;
	logic     shiftByShamtDec;
	extOp_t   extOpDec;
	logic     memReadDec;
	logic     memWriteDec;
	dmSel_t   dmSelDec;
	logic     regWriteDec;
	destSel_t destSelDec;
	wbSel_t   wbSelDec;
	npcOp_t   npcOpDec;
	logic     isBranchDec;
	logic     exceptionDec;
	excCode_t excCodeDec;

	assign opcode = instr[`FLD_OP];
	assign rt     = instr[`FLD_RT]; // REGIMM selector
	assign funct  = instr[`FLD_FUNCT];

	aluDecode u_aluDecode (
		.opcode(opcode), .funct(funct),
		.aluOp(aluOpDec), .shiftByShamt(shiftByShamtDec), .extOp(extOpDec)
	);
	memDecode u_memDecode (
		.opcode(opcode), .memRead(memReadDec), .memWrite(memWriteDec), .dmSel(dmSelDec)
	);
	branchResolve u_branchResolve (
		.opcode(opcode), .funct(funct), .rt(rt), .rsVal(rsVal), .rtVal(rtVal),
		.isBranch(isBranchDec), .npcOp(npcOpDec)
	);
	regWriteDecode u_regWriteDecode (
		.opcode(opcode), .funct(funct), .rt(rt),
		.regWrite(regWriteDec), .destSel(destSelDec), .wbSel(wbSelDec)
	);
	excDetect u_excDetect (
		.opcode(opcode), .funct(funct),
		.regWrite(regWriteDec), .memWrite(memWriteDec), .isBranch(isBranchDec),
		.exception(exceptionDec), .excCode(excCodeDec)
	);

	// Handshake controller and output register
	decodeStage u_decodeStage (.*);

endmodule

// File: tbIdDecode.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module tbIdDecode;
	import decodePkg::*;

	localparam int ackTimeout = 16; // Cycles allowed per ack edge

	typedef struct packed {
		word_t instr, rsVal, rtVal;
		aluOp_t aluOp;
		logic shiftByShamt;
		extOp_t extOp;
		logic memRead, memWrite;
		dmSel_t dmSel;
		logic regWrite;
		destSel_t destSel;
		wbSel_t wbSel;
		npcOp_t npcOp;
		logic isBranch, exception;
		excCode_t excCode;
	} row_t;

	logic clk = 1'b0;
	logic rst, req, ack;
	word_t instr, rsVal, rtVal;
	logic shiftByShamt, memRead, memWrite, regWrite, isBranch, inDelaySlot, exception;
	aluOp_t aluOp;
	extOp_t extOp;
	dmSel_t dmSel;
	destSel_t destSel;
	wbSel_t wbSel;
	npcOp_t npcOp;
	excCode_t excCode;

	row_t rows[$];
	row_t last;                  // Word the outputs must hold
	logic lastSlot;
	logic [31:0] lfsr = 32'h6537;
	logic timedOut = 1'b0;
	int mismatches = 0;
	int hsErrors = 0;

	always #50 clk = ~clk;

	idDecode u_idDecode (.*);

	function automatic word_t encodeR(input regAddr_t rs, input regAddr_t rt, input regAddr_t rd,
		input logic [4:0] shamt, input funct_t fn);
		return {`OP_RTYPE, rs, rt, rd, shamt, fn};
	endfunction

	function automatic word_t encodeI(input opcode_t op, input regAddr_t rs, input regAddr_t rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic aluRow(input word_t ins, input aluOp_t op, input logic shift,
		input extOp_t ext, input destSel_t dest, input wbSel_t wb);
		rows.push_back(row_t'{ins, 32'd0, 32'd0, op, shift, ext, 1'b0, 1'b0, `DM_LW, 1'b1,
			dest, wb, `NPC_SEQ, 1'b0, 1'b0, `EXC_NONE});
	endtask

	task automatic memRow(input opcode_t op, input logic load, input dmSel_t dm);
		rows.push_back(row_t'{encodeI(op, 5'd1, 5'd2, 16'h0004), 32'd0, 32'd0, `ALU_ADD, 1'b0,
			`EXT_SIGN, load, !load, dm, load, `DEST_RT, load ? `WB_MEM : `WB_ALU, `NPC_SEQ,
			1'b0, 1'b0, `EXC_NONE});
	endtask

	// Linking REGIMM branches write r31 whether taken or not
	task automatic condRow(input opcode_t op, input regAddr_t rtField, input word_t rs,
		input word_t rt, input logic taken, input logic link);
		rows.push_back(row_t'{encodeI(op, 5'd1, rtField, 16'h0008), rs, rt, `ALU_NONE, 1'b0,
			`EXT_ZERO, 1'b0, 1'b0, `DM_LW, link, link ? `DEST_RA : `DEST_RT,
			link ? `WB_RA : `WB_ALU, taken ? `NPC_BRANCH : `NPC_SEQ, 1'b1, 1'b0, `EXC_NONE});
	endtask

	task automatic jumpRow(input word_t ins, input npcOp_t npc, input logic link,
		input destSel_t dest);
		rows.push_back(row_t'{ins, 32'd0, 32'd0, `ALU_NONE, 1'b0, `EXT_ZERO, 1'b0, 1'b0, `DM_LW,
			link, dest, link ? `WB_RA : `WB_ALU, npc, 1'b1, 1'b0, `EXC_NONE});
	endtask

	task automatic excRow(input word_t ins, input excCode_t code, input destSel_t dest);
		rows.push_back(row_t'{ins, 32'd0, 32'd0, `ALU_NONE, 1'b0, `EXT_ZERO, 1'b0, 1'b0, `DM_LW,
			1'b0, dest, `WB_ALU, `NPC_SEQ, 1'b0, 1'b1, code});
	endtask

	task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			mismatches++;
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic checkExpect(input row_t r, input logic slot, input logic full);
		checkField("regWrite", 32'(regWrite), 32'(r.regWrite));
		checkField("memRead", 32'(memRead), 32'(r.memRead));
		checkField("memWrite", 32'(memWrite), 32'(r.memWrite));
		checkField("npcOp", 32'(npcOp), 32'(r.npcOp));
		checkField("isBranch", 32'(isBranch), 32'(r.isBranch));
		checkField("inDelaySlot", 32'(inDelaySlot), 32'(slot));
		checkField("exception", 32'(exception), 32'(r.exception));
		checkField("excCode", 32'(excCode), 32'(r.excCode));
		if (full) begin // Datapath selects are unknown until the first capture
			checkField("aluOp", 32'(aluOp), 32'(r.aluOp));
			checkField("shiftByShamt", 32'(shiftByShamt), 32'(r.shiftByShamt));
			checkField("extOp", 32'(extOp), 32'(r.extOp));
			checkField("dmSel", 32'(dmSel), 32'(r.dmSel));
			checkField("destSel", 32'(destSel), 32'(r.destSel));
			checkField("wbSel", 32'(wbSel), 32'(r.wbSel));
		end
	endtask

	// Counts rising edges until ack is seen at the given level
	task automatic waitAck(input logic level, output int cycles);
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end while (ack !== level && cycles < ackTimeout);
		assert (ack === level) else begin
			hsErrors++;
			timedOut = 1'b1;
			$display("ack did not go %s within %0d cycles", level ? "high" : "low", ackTimeout);
		end
	endtask

	initial begin
		int cycles;
		logic [1:0] gap;
		rst = 1'b0;
		req = 1'b0;
		instr = '0;
		rsVal = '0;
		rtVal = '0;
		last = row_t'{32'd0, 32'd0, 32'd0, `ALU_NONE, 1'b0, `EXT_ZERO, 1'b0, 1'b0, `DM_LW,
			1'b0, `DEST_RT, `WB_ALU, `NPC_SEQ, 1'b0, 1'b0, `EXC_NONE};
		lastSlot = 1'b0;

		aluRow(encodeR(5'd1, 5'd2, 5'd3, 5'd0, `FN_ADD),
			`ALU_ADD, 1'b0, `EXT_ZERO, `DEST_RD, `WB_ALU);
		aluRow(encodeR(5'd1, 5'd2, 5'd3, 5'd0, `FN_SUBU),
			`ALU_SUBU, 1'b0, `EXT_ZERO, `DEST_RD, `WB_ALU);
		aluRow(encodeR(5'd0, 5'd2, 5'd3, 5'd4, `FN_SLL),
			`ALU_SLL, 1'b1, `EXT_ZERO, `DEST_RD, `WB_ALU);
		aluRow(encodeR(5'd1, 5'd2, 5'd3, 5'd0, `FN_SRAV),
			`ALU_SRA, 1'b0, `EXT_ZERO, `DEST_RD, `WB_ALU);
		aluRow(encodeI(`OP_ORI, 5'd1, 5'd2, 16'h00ff),
			`ALU_OR, 1'b0, `EXT_ZERO, `DEST_RT, `WB_ALU);
		aluRow(encodeI(`OP_LUI, 5'd0, 5'd2, 16'h1234),
			`ALU_NONE, 1'b0, `EXT_UPPER, `DEST_RT, `WB_LUI);
		aluRow(encodeI(`OP_SLTI, 5'd1, 5'd2, 16'hffff),
			`ALU_SLT, 1'b0, `EXT_SIGN, `DEST_RT, `WB_ALU);
		memRow(`OP_LB, 1'b1, `DM_LB);
		memRow(`OP_LBU, 1'b1, `DM_LBU);
		memRow(`OP_LH, 1'b1, `DM_LH);
		memRow(`OP_LHU, 1'b1, `DM_LHU);
		memRow(`OP_LW, 1'b1, `DM_LW);
		memRow(`OP_SB, 1'b0, `DM_SB);
		memRow(`OP_SH, 1'b0, `DM_SH);
		memRow(`OP_SW, 1'b0, `DM_SW);
		condRow(`OP_BEQ, 5'd2, 32'd5, 32'd5, 1'b1, 1'b0);
		condRow(`OP_BEQ, 5'd2, 32'd5, 32'd6, 1'b0, 1'b0);
		condRow(`OP_BNE, 5'd2, 32'd5, 32'd6, 1'b1, 1'b0);
		condRow(`OP_BNE, 5'd2, 32'd7, 32'd7, 1'b0, 1'b0);
		condRow(`OP_BLEZ, 5'd0, 32'd0, 32'd0, 1'b1, 1'b0); // Zero is taken
		condRow(`OP_BLEZ, 5'd0, 32'hffff_ff00, 32'd0, 1'b1, 1'b0);
		condRow(`OP_BLEZ, 5'd0, 32'd1, 32'd0, 1'b0, 1'b0);
		condRow(`OP_BGTZ, 5'd0, 32'd9, 32'd0, 1'b1, 1'b0);
		condRow(`OP_BGTZ, 5'd0, 32'h8000_0000, 32'd0, 1'b0, 1'b0);
		condRow(`OP_REGIMM, `RT_BLTZ, 32'hffff_ffff, 32'd0, 1'b1, 1'b0);
		condRow(`OP_REGIMM, `RT_BLTZ, 32'd0, 32'd0, 1'b0, 1'b0);
		condRow(`OP_REGIMM, `RT_BGEZ, 32'd0, 32'd0, 1'b1, 1'b0);
		condRow(`OP_REGIMM, `RT_BGEZ, 32'hffff_fffb, 32'd0, 1'b0, 1'b0);
		condRow(`OP_REGIMM, `RT_BLTZAL, 32'hffff_fffe, 32'd0, 1'b1, 1'b1);
		condRow(`OP_REGIMM, `RT_BLTZAL, 32'd4, 32'd0, 1'b0, 1'b1);
		condRow(`OP_REGIMM, `RT_BGEZAL, 32'd4, 32'd0, 1'b1, 1'b1);
		condRow(`OP_REGIMM, `RT_BGEZAL, 32'h8000_0000, 32'd0, 1'b0, 1'b1);
		jumpRow({`OP_J, 26'h0000100}, `NPC_JIMM, 1'b0, `DEST_RT);
		jumpRow({`OP_JAL, 26'h0000200}, `NPC_JIMM, 1'b1, `DEST_RA);
		jumpRow(encodeR(`REG_RA, 5'd0, 5'd0, 5'd0, `FN_JR), `NPC_JREG, 1'b0, `DEST_RD);
		jumpRow(encodeR(5'd4, 5'd0, `REG_RA, 5'd0, `FN_JALR), `NPC_JREG, 1'b1, `DEST_RD);
		excRow(encodeR(5'd0, 5'd0, 5'd0, 5'd0, `FN_SYSCALL), `EXC_SYS, `DEST_RD);
		excRow(encodeR(5'd0, 5'd0, 5'd0, 5'd0, `FN_BREAK), `EXC_BP, `DEST_RD);
		excRow(encodeI(6'b111111, 5'd1, 5'd2, 16'h0000), `EXC_RI, `DEST_RT); // Unused opcode

		repeat (3) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		checkField("ack", 32'(ack), 32'd0);
		checkExpect(last, 1'b0, 1'b0);

		for (int i = 0; i < rows.size() && !timedOut; i++) begin
			lfsr = lfsrStep(lfsr);
			gap[0] = lfsr[0];
			lfsr = lfsrStep(lfsr);
			gap[1] = lfsr[0];
			repeat (gap) begin // Idle cycles hold the previous word
				@(negedge clk);
				checkField("ack", 32'(ack), 32'd0);
				checkExpect(last, lastSlot, i > 0);
			end
			@(posedge clk);
			instr <= rows[i].instr;
			rsVal <= rows[i].rsVal;
			rtVal <= rows[i].rtVal;
			req <= 1'b1;
			waitAck(1'b1, cycles);
			if (!timedOut) begin
				assert (cycles == 1) else begin
					hsErrors++;
					$display("ack for row %0d came after %0d cycles instead of 1", i, cycles);
				end
				lastSlot = (i > 0) && rows[i - 1].isBranch; // Follows a branch or jump
				last = rows[i];
				checkExpect(last, lastSlot, 1'b1);
				@(posedge clk);
				req <= 1'b0;
				waitAck(1'b0, cycles);
				if (!timedOut) begin
					assert (cycles == 1) else begin
						hsErrors++;
						$display("ack for row %0d fell after %0d cycles instead of 1", i, cycles);
					end
				end
			end
		end

		$display("mismatches: %0d, handshake errors: %0d", mismatches, hsErrors);
		if (mismatches == 0 && hsErrors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: sources.f
+incdir+.
decodePkg.sv
aluDecode.sv
memDecode.sv
branchResolve.sv
regWriteDecode.sv
excDetect.sv
decodeStage.sv
idDecode.sv
tbIdDecode.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tbIdDecode -o simIdDecode
result=$(./obj_dir/simIdDecode)
echo "$result"
if echo "$result" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
